/* common/scpuPkg.sv */
package scpuPkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////
	localparam int dataWidth    = 32;   // Word, PC and bus width
	localparam int regAddrWidth = 5;    // rs, rt, rd fields
	localparam int regCount     = 32;   // Including hardwired r0
	localparam int opWidth      = 6;    // Opcode and funct fields
	localparam int aluCtrlWidth = 3;
	localparam int shamtWidth   = 5;
	localparam int immWidth     = 16;   // I-type immediate
	localparam int jIdxWidth    = 26;   // J-type target index

	// PC after reset and per-instruction step
	localparam logic [dataWidth-1:0] resetPc = '0;
	localparam logic [dataWidth-1:0] pcStep  = 'd4;

	////////////////////////////////////////
	// Opcodes, instr[31:26]
	////////////////////////////////////////
	localparam logic [opWidth-1:0] opR    = 6'b000000;  // All R-type
	localparam logic [opWidth-1:0] opLw   = 6'b100011;
	localparam logic [opWidth-1:0] opSw   = 6'b101011;
	localparam logic [opWidth-1:0] opBeq  = 6'b000100;
	localparam logic [opWidth-1:0] opJ    = 6'b000010;
	localparam logic [opWidth-1:0] opSlti = 6'h24;      // Team encoding, not stock MIPS

	////////////////////////////////////////
	// R-type function codes, instr[5:0]
	////////////////////////////////////////
	localparam logic [opWidth-1:0] fnAdd = 6'b100000;
	localparam logic [opWidth-1:0] fnSub = 6'b100010;
	localparam logic [opWidth-1:0] fnAnd = 6'b100100;
	localparam logic [opWidth-1:0] fnOr  = 6'b100101;
	localparam logic [opWidth-1:0] fnSlt = 6'b101010;
	localparam logic [opWidth-1:0] fnNor = 6'b100111;
	localparam logic [opWidth-1:0] fnSrl = 6'b000010;
	localparam logic [opWidth-1:0] fnXor = 6'b010110;   // Team encoding

	////////////////////////////////////////
	// ALU operation codes
	////////////////////////////////////////
	localparam logic [aluCtrlWidth-1:0] aluAnd = 3'b000;
	localparam logic [aluCtrlWidth-1:0] aluOr  = 3'b001;
	localparam logic [aluCtrlWidth-1:0] aluAdd = 3'b010;  // Also lw/sw address
	localparam logic [aluCtrlWidth-1:0] aluXor = 3'b011;
	localparam logic [aluCtrlWidth-1:0] aluNor = 3'b100;
	localparam logic [aluCtrlWidth-1:0] aluSrl = 3'b101;
	localparam logic [aluCtrlWidth-1:0] aluSub = 3'b110;  // Also beq compare
	localparam logic [aluCtrlWidth-1:0] aluSlt = 3'b111;  // slt and slti

endpackage

/* hw/scpuCtrl.sv */
module scpuCtrl (
	input  logic [scpuPkg::opWidth-1:0]      opcode,   // instr[31:26]
	input  logic [scpuPkg::opWidth-1:0]      funct,    // instr[5:0]
	output logic                             regDst,   // rd instead of rt
	output logic                             aluSrcB,  // Immediate as ALU b
	output logic                             memToReg, // Load data to register
	output logic                             regWrite,
	output logic                             memRead,
	output logic                             memWrite,
	output logic                             branch,
	output logic                             jump,
	output logic [scpuPkg::aluCtrlWidth-1:0] aluCtrl
);

	// {regDst, aluSrcB, memToReg, regWrite, memRead, memWrite, branch, jump, aluOp[1:0]}
	logic [9:0] ctrlBits;
	logic [1:0] aluOp;
	logic       fnValid;  // Low for an R-type funct outside the subset

	////////////////////////////////////////
	// Main decoder
	////////////////////////////////////////
	always_comb begin
		case (opcode)
			scpuPkg::opR:    ctrlBits = 10'b1001000010;  // ALU op from funct
			scpuPkg::opLw:   ctrlBits = 10'b0111100000;  // memRead set for the bus
			scpuPkg::opSw:   ctrlBits = 10'b0100010000;
			scpuPkg::opBeq:  ctrlBits = 10'b0000001001;  // Subtract, test zero
			scpuPkg::opJ:    ctrlBits = 10'b0000000100;  // aluOp 00 so funct bits never matter
			scpuPkg::opSlti: ctrlBits = 10'b0101000011;
			default:         ctrlBits = 10'b0000000000;  // No-op
		endcase
	end

	assign aluOp = ctrlBits[1:0];

	////////////////////////////////////////
	// ALU control
	////////////////////////////////////////
	always_comb begin
		fnValid = 1'b1;
		case (aluOp)
			2'b00: aluCtrl = scpuPkg::aluAdd;  // lw, sw, j, no-op
			2'b01: aluCtrl = scpuPkg::aluSub;  // beq
			2'b10: begin
				case (funct)
					scpuPkg::fnAdd: aluCtrl = scpuPkg::aluAdd;
					scpuPkg::fnSub: aluCtrl = scpuPkg::aluSub;
					scpuPkg::fnAnd: aluCtrl = scpuPkg::aluAnd;
					scpuPkg::fnOr:  aluCtrl = scpuPkg::aluOr;
					scpuPkg::fnSlt: aluCtrl = scpuPkg::aluSlt;
					scpuPkg::fnNor: aluCtrl = scpuPkg::aluNor;
					scpuPkg::fnSrl: aluCtrl = scpuPkg::aluSrl;
					scpuPkg::fnXor: aluCtrl = scpuPkg::aluXor;
					default: begin
						// Unknown funct retires as a no-op
						aluCtrl = scpuPkg::aluAdd;
						fnValid = 1'b0;
					end
				endcase
			end
			default: aluCtrl = scpuPkg::aluSlt;  // slti
		endcase
	end

	// Bad funct clears every strobe, PC still steps by four
	assign {regDst, aluSrcB, memToReg, regWrite, memRead, memWrite, branch, jump} =
		fnValid ? ctrlBits[9:2] : 8'b0;

endmodule

/* hw/regFile.sv */
module regFile (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [scpuPkg::regAddrWidth-1:0] rdAddrA,  // rs
	input  logic [scpuPkg::regAddrWidth-1:0] rdAddrB,  // rt
	input  logic [scpuPkg::regAddrWidth-1:0] wrAddr,
	input  logic                             wrEn,     // Already stall-gated
	input  logic [scpuPkg::dataWidth-1:0]    wrData,
	output logic [scpuPkg::dataWidth-1:0]    rdDataA,
	output logic [scpuPkg::dataWidth-1:0]    rdDataB
);

	// r0 has no storage
	logic [scpuPkg::dataWidth-1:0] regs [1:scpuPkg::regCount-1];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < scpuPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin  // Writes to r0 dropped
			regs[wrAddr] <= wrData;
		end
	end

	// Combinational reads, r0 reads zero
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

/* hw/scpuAlu.sv */
module scpuAlu (
	input  logic [scpuPkg::aluCtrlWidth-1:0] aluCtrl,
	input  logic [scpuPkg::dataWidth-1:0]    a,       // rs
	input  logic [scpuPkg::dataWidth-1:0]    b,       // rt or immediate
	input  logic [scpuPkg::shamtWidth-1:0]   shamt,   // srl only
	output logic [scpuPkg::dataWidth-1:0]    result,
	output logic                             zero     // For beq
);

	logic sltBit;

	// Signed compare for slt and slti
	assign sltBit = $signed(a) < $signed(b);

	////////////////////////////////////////
	// Operation select
	////////////////////////////////////////
	always_comb begin
		case (aluCtrl)
			scpuPkg::aluAnd: result = a & b;
			scpuPkg::aluOr:  result = a | b;
			scpuPkg::aluAdd: result = a + b;     // Wraps, no overflow trap
			scpuPkg::aluXor: result = a ^ b;
			scpuPkg::aluNor: result = ~(a | b);
			scpuPkg::aluSrl: result = b >> shamt;  // Logical, zero fill
			scpuPkg::aluSub: result = a - b;
			scpuPkg::aluSlt: begin
				// Zero-extended flag
				result = {{(scpuPkg::dataWidth-1){1'b0}}, sltBit};
			end
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* hw/apbDataPort.sv */
module apbDataPort (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          rdReq,    // lw presented
	input  logic                          wrReq,    // sw presented
	input  logic [scpuPkg::dataWidth-1:0] addr,
	input  logic [scpuPkg::dataWidth-1:0] wrData,
	output logic                          done,     // One cycle, transfer complete
	output logic [scpuPkg::dataWidth-1:0] rdData,
	output logic                          psel,
	output logic                          penable,
	output logic                          pwrite,
	output logic [scpuPkg::dataWidth-1:0] paddr,
	output logic [scpuPkg::dataWidth-1:0] pwdata,
	input  logic [scpuPkg::dataWidth-1:0] prdata,
	input  logic                          pready
);

	// stIdle is the quiet cycle after reset or completion
	// stSetup drives the setup phase as soon as a request shows up
	typedef enum logic [1:0] {stIdle, stSetup, stAccess} apbStateT;

	apbStateT                      state;
	apbStateT                      stateNext;
	logic                          req;
	logic                          start;    // Setup phase this cycle
	logic                          writeQ;
	logic [scpuPkg::dataWidth-1:0] addrQ;
	logic [scpuPkg::dataWidth-1:0] dataQ;

	assign req   = rdReq | wrReq;
	assign start = (state == stSetup) && req;

	////////////////////////////////////////
	// State and captured transfer
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state  <= stIdle;
			writeQ <= 1'b0;
		end else begin
			state <= stateNext;
			if (start) writeQ <= wrReq;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addrQ <= addr;    // Held through access phase
			dataQ <= wrData;
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			stIdle:   stateNext = stSetup;
			stSetup:  if (req) stateNext = stAccess;
			stAccess: if (pready) stateNext = stIdle;  // Wait states loop here
			default:  stateNext = stIdle;
		endcase
	end

	// Bus outputs
	assign psel    = start || (state == stAccess);
	assign penable = (state == stAccess);
	assign pwrite  = (state == stAccess) ? writeQ : (start && wrReq);
	assign paddr   = (state == stAccess) ? addrQ : addr;
	assign pwdata  = (state == stAccess) ? dataQ : wrData;

	assign done   = (state == stAccess) && pready;
	assign rdData = prdata;  // Sampled by the core only with done

endmodule

/* hw/scpuCore.sv */
module scpuCore (
	input  logic                          clk,
	input  logic                          rstN,
	output logic [scpuPkg::dataWidth-1:0] instrAddr,  // PC to instruction port
	input  logic [scpuPkg::dataWidth-1:0] instr,      // Same-cycle return
	output logic                          psel,
	output logic                          penable,
	output logic                          pwrite,
	output logic [scpuPkg::dataWidth-1:0] paddr,
	output logic [scpuPkg::dataWidth-1:0] pwdata,
	input  logic [scpuPkg::dataWidth-1:0] prdata,
	input  logic                          pready
);

	localparam int dw = scpuPkg::dataWidth;

	logic [dw-1:0] pc;
	logic [dw-1:0] pcPlus4;
	logic [dw-1:0] nextPc;
	logic [dw-1:0] branchTarget;
	logic [dw-1:0] jumpTarget;
	logic [dw-1:0] signImm;

	// Decoder outputs
	logic                             regDst;
	logic                             aluSrcB;
	logic                             memToReg;
	logic                             regWrite;
	logic                             memRead;
	logic                             memWrite;
	logic                             branch;
	logic                             jump;
	logic [scpuPkg::aluCtrlWidth-1:0] aluCtrl;

	// Datapath
	logic [scpuPkg::regAddrWidth-1:0] wrAddr;
	logic [scpuPkg::shamtWidth-1:0]   shamt;
	logic [dw-1:0]                    rdDataA;
	logic [dw-1:0]                    rdDataB;
	logic [dw-1:0]                    aluB;
	logic [dw-1:0]                    aluResult;
	logic                             aluZero;
	logic [dw-1:0]                    memRdData;
	logic [dw-1:0]                    wrData;
	logic                             memDone;
	logic                             stall;     // Memory op still on the bus

	////////////////////////////////////////
	// Program counter
	////////////////////////////////////////
	assign pcPlus4   = pc + scpuPkg::pcStep;
	assign signImm   = {{(dw-scpuPkg::immWidth){instr[15]}}, instr[scpuPkg::immWidth-1:0]};
	assign branchTarget = pcPlus4 + {signImm[dw-3:0], 2'b00};
	assign jumpTarget   = {pcPlus4[dw-1:dw-4], instr[scpuPkg::jIdxWidth-1:0], 2'b00};

	always_comb begin
		if (jump) nextPc = jumpTarget;
		else if (branch && aluZero) nextPc = branchTarget;  // beq taken
		else nextPc = pcPlus4;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) pc <= scpuPkg::resetPc;
		else if (!stall) pc <= nextPc;  // Frozen while pready low
	end

	assign instrAddr = pc;
	assign stall     = (memRead || memWrite) && !memDone;

	////////////////////////////////////////
	// Decode and datapath
	////////////////////////////////////////
	scpuCtrl ctrl0 (
		.opcode(instr[31:26]), .funct(instr[5:0]),
		.regDst(regDst), .aluSrcB(aluSrcB), .memToReg(memToReg), .regWrite(regWrite),
		.memRead(memRead), .memWrite(memWrite), .branch(branch), .jump(jump),
		.aluCtrl(aluCtrl)
	);

	assign wrAddr = regDst ? instr[15:11] : instr[20:16];  // rd or rt
	assign shamt  = instr[10:6];
	assign aluB   = aluSrcB ? signImm : rdDataB;
	assign wrData = memToReg ? memRdData : aluResult;

	regFile rf0 (
		.clk(clk), .rstN(rstN),
		.rdAddrA(instr[25:21]), .rdAddrB(instr[20:16]), .wrAddr(wrAddr),
		.wrEn(regWrite && !stall),  // Load writes on its done edge
		.wrData(wrData), .rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	scpuAlu alu0 (
		.aluCtrl(aluCtrl), .a(rdDataA), .b(aluB), .shamt(shamt),
		.result(aluResult), .zero(aluZero)
	);

	// Base plus offset from the ALU, store data from rt
	apbDataPort apb0 (
		.clk(clk), .rstN(rstN),
		.rdReq(memRead), .wrReq(memWrite), .addr(aluResult), .wrData(rdDataB),
		.done(memDone), .rdData(memRdData),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready)
	);

endmodule

/* test/scpuCore_properties.sv */
module scpuCoreProperties (
	input logic                          clk,
	input logic                          rstN,
	input logic                          psel,
	input logic                          penable,
	input logic                          pwrite,
	input logic [scpuPkg::dataWidth-1:0] paddr,
	input logic [scpuPkg::dataWidth-1:0] pwdata,
	input logic                          pready
);

	int failCount = 0;  // Read by the testbench

	////////////////////////////////////////
	// APB handshake
	////////////////////////////////////////
	property setupThenAccess;  // Setup lasts one cycle
		@(posedge clk) disable iff (!rstN) (psel && !penable) |=> (psel && penable);
	endproperty

	property heldUntilReady;   // Address, direction, data frozen
		@(posedge clk) disable iff (!rstN)
			(psel && !(penable && pready)) |=>
				($stable(paddr) && $stable(pwrite) && $stable(pwdata));
	endproperty

	property dropAfterDone;
		@(posedge clk) disable iff (!rstN) (penable && pready) |=> (!psel && !penable);
	endproperty

	// Bus quiet while held in reset
	property quietInReset;
		@(posedge clk) !rstN |-> (!psel && !penable);
	endproperty

	assert property (setupThenAccess) else begin
		failCount = failCount + 1;
		$error("setup phase not followed by access phase");
	end
	assert property (heldUntilReady) else begin
		failCount = failCount + 1;
		$error("paddr, pwrite or pwdata changed during transfer");
	end
	assert property (dropAfterDone) else begin
		failCount = failCount + 1;
		$error("psel or penable still high after completion");
	end
	assert property (quietInReset) else begin
		failCount = failCount + 1;
		$error("APB active during reset");
	end

endmodule

bind scpuCore scpuCoreProperties props0 (
	.clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
	.paddr(paddr), .pwdata(pwdata), .pready(pready)
);

/* test/scpuTb.sv */
module scpuTb;

	localparam int progLen    = 200;  // Words, last one is the self-jump
	localparam int memTimeout = 16;   // Cycles allowed per APB transfer
	localparam int runLimit   = 600;  // Retirements before giving up
	localparam logic [31:0] lfsrTaps = 32'hB4BCD35C;

	// One retirement as the ISA defines it
	typedef struct packed {
		logic [31:0] nextPc;
		logic        regWe;
		logic [4:0]  regAddr;
		logic [31:0] regVal;
		logic        memRd;
		logic        memWr;
		logic [31:0] memAddr;
		logic [31:0] memData;
	} stepT;

	logic        clk = 1'b0;
	logic        rstN;
	logic [31:0] instrAddr;
	logic [31:0] instr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic [31:0] lfsr;
	logic [31:0] progMem [0:255];
	logic [31:0] dataMem [0:63];  // Served by the APB slave
	logic [31:0] refMem [0:63];   // Model's own copy
	logic [31:0] refRegs [0:31];
	logic [5:0]  fnTable [0:7];
	int          waitLeft;

	always #2 clk = ~clk;

	assign instr = progMem[instrAddr[9:2]];  // Same-cycle fetch

	scpuCore dut0 (
		.clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};  // One LFSR step per bit
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsrTaps) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {scpuPkg::opR, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeJ(input logic [25:0] idx);
		return {scpuPkg::opJ, idx};
	endfunction

	function automatic bit isKnownOp(input logic [5:0] op);
		return op == scpuPkg::opR || op == scpuPkg::opLw || op == scpuPkg::opSw ||
			op == scpuPkg::opBeq || op == scpuPkg::opJ || op == scpuPkg::opSlti;
	endfunction

	function automatic bit isKnownFunct(input logic [5:0] fn);
		bit hit;
		hit = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (fnTable[i] == fn) hit = 1'b1;
		end
		return hit;
	endfunction

	// Word contents mix every address bit
	function automatic logic [31:0] fillWord(input logic [7:0] a);
		return (32'h9e3779b9 * {24'h0, a}) ^ {a, ~a, a, ~a};
	endfunction

	////////////////////////////////////////
	// ISA reference
	////////////////////////////////////////
	function automatic stepT scpuStep(input logic [31:0] pc, input logic [31:0] ins,
			input logic [31:0] rsVal, input logic [31:0] rtVal);
		stepT        s;
		logic [31:0] imm;
		logic [31:0] seq;
		s   = '0;
		imm = {{16{ins[15]}}, ins[15:0]};
		seq = pc + 32'd4;
		s.nextPc = seq;
		case (ins[31:26])
			scpuPkg::opR: begin
				s.regWe   = 1'b1;
				s.regAddr = ins[15:11];
				case (ins[5:0])
					scpuPkg::fnAdd: s.regVal = rsVal + rtVal;
					scpuPkg::fnSub: s.regVal = rsVal - rtVal;
					scpuPkg::fnAnd: s.regVal = rsVal & rtVal;
					scpuPkg::fnOr:  s.regVal = rsVal | rtVal;
					scpuPkg::fnSlt: s.regVal = {31'b0, $signed(rsVal) < $signed(rtVal)};
					scpuPkg::fnNor: s.regVal = ~(rsVal | rtVal);
					scpuPkg::fnSrl: s.regVal = rtVal >> ins[10:6];
					scpuPkg::fnXor: s.regVal = rsVal ^ rtVal;
					default:        s.regWe  = 1'b0;  // Unknown funct, no-op
				endcase
			end
			scpuPkg::opLw: begin
				s.memRd   = 1'b1;
				s.regWe   = 1'b1;
				s.regAddr = ins[20:16];
				s.memAddr = rsVal + imm;  // Data filled in by caller
			end
			scpuPkg::opSw: begin
				s.memWr   = 1'b1;
				s.memAddr = rsVal + imm;
				s.memData = rtVal;
			end
			scpuPkg::opBeq: if (rsVal == rtVal) s.nextPc = seq + {imm[29:0], 2'b00};
			scpuPkg::opJ:   s.nextPc = {seq[31:28], ins[25:0], 2'b00};
			scpuPkg::opSlti: begin
				s.regWe   = 1'b1;
				s.regAddr = ins[20:16];
				s.regVal  = {31'b0, $signed(rsVal) < $signed(imm)};
			end
			default: ;  // Unknown opcode, PC + 4 only
		endcase
		return s;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, expected);
			$display("TEST FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run aborted");
	endtask

	////////////////////////////////////////
	// Program generator
	////////////////////////////////////////
	task automatic buildProgram();
		int         p;
		logic [2:0] kind;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] dumpReg;
		logic [5:0] code;
		p = 0;
		for (int i = 0; i < 256; i++) begin
			progMem[i] = '0;  // Zero word is an unknown funct
		end
		for (int i = 0; i < 32; i++) begin  // Dump every register, all zero
			progMem[p] = encodeI(scpuPkg::opSw, 5'd0, 5'(i), 16'(i * 4));
			p++;
		end
		while (p < progLen - 8) begin
			kind    = 3'(randBits(3));
			rs      = 5'(randBits(5));
			rt      = 5'(randBits(5));
			rd      = 5'(randBits(5));
			dumpReg = rt;
			case (kind)
				3'd0, 3'd1: begin
					progMem[p] = encodeR(rs, rt, rd, 5'(randBits(5)), fnTable[randBits(3)]);
					dumpReg = rd;
				end
				3'd2: progMem[p] = encodeI(scpuPkg::opSlti, rs, rt, 16'(randBits(16)));
				3'd3: progMem[p] = encodeI(scpuPkg::opLw, rs, rt, 16'(randBits(16)));
				3'd4: progMem[p] = encodeI(scpuPkg::opSw, rs, rt, 16'(randBits(16)));
				3'd5: begin
					if (randBits(1) == 1) rt = rs;  // Force taken
					progMem[p] = encodeI(scpuPkg::opBeq, rs, rt, 16'(randBits(2)));
				end
				3'd6: progMem[p] = encodeJ(26'(p + 1 + randBits(2)));  // Forward only
				default: begin
					code = 6'(randBits(6));
					if (randBits(1) == 1) begin
						if (isKnownOp(code)) code = 6'h3f;
						progMem[p] = {code, rs, rt, 16'(randBits(16))};
					end else begin
						if (isKnownFunct(code)) code = 6'h3f;
						progMem[p] = encodeR(rs, rt, rd, 5'd0, code);
						dumpReg = rd;
					end
				end
			endcase
			p++;
			if (kind != 3'd4 && kind != 3'd5 && kind != 3'd6) begin
				progMem[p] = encodeI(scpuPkg::opSw, 5'd0, dumpReg, 16'(randBits(16)));
				p++;
			end
		end
		progMem[progLen - 1] = encodeJ(26'(progLen - 1));  // End of program
	endtask

	////////////////////////////////////////
	// APB slave, 0 to 3 wait states
	////////////////////////////////////////
	always @(posedge clk) begin
		if (!rstN) begin
			pready <= 1'b0;
		end else if (psel && penable && pready) begin
			if (pwrite) dataMem[paddr[7:2]] <= pwdata;
			pready <= 1'b0;
		end else if (psel && !penable) begin  // Setup ends here
			waitLeft = int'(randBits(2));
			pready <= (waitLeft == 0);
			prdata <= dataMem[paddr[7:2]];
		end else if (psel && penable) begin
			waitLeft = waitLeft - 1;
			pready <= (waitLeft == 0);
		end
	end

	always @(negedge clk) begin
		if (dut0.props0.failCount != 0) failRun("an APB protocol assertion failed");
	end

	////////////////////////////////////////
	// Reset, then compare every retirement
	////////////////////////////////////////
	initial begin
		stepT        st;
		logic [31:0] cur;
		logic [31:0] refPc;
		int          cycles;
		int          retired;
		bit          running;
		rstN   <= 1'b0;
		pready <= 1'b0;
		prdata <= '0;
		lfsr    = 32'h687f95ef;
		fnTable = '{scpuPkg::fnAdd, scpuPkg::fnSub, scpuPkg::fnAnd, scpuPkg::fnOr,
			scpuPkg::fnSlt, scpuPkg::fnNor, scpuPkg::fnSrl, scpuPkg::fnXor};
		buildProgram();
		for (int i = 0; i < 64; i++) begin
			dataMem[i] = fillWord(8'(i * 4));
			refMem[i]  = fillWord(8'(i * 4));
		end
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = '0;
		end
		repeat (3) begin  // Held in reset
			@(posedge clk);
			checkValue("psel", psel, 1'b0);
			checkValue("penable", penable, 1'b0);
			checkValue("instrAddr", instrAddr, scpuPkg::resetPc);
		end
		rstN <= 1'b1;
		refPc   = scpuPkg::resetPc;
		retired = 0;
		running = 1'b1;
		@(negedge clk);
		while (running) begin
			cur = progMem[refPc[9:2]];
			checkValue("instrAddr", instrAddr, refPc);
			st = scpuStep(refPc, cur, refRegs[cur[25:21]], refRegs[cur[20:16]]);
			if (st.memRd || st.memWr) begin
				cycles = 0;
				while (!(psel && penable && pready)) begin  // PC must hold meanwhile
					checkValue("instrAddr", instrAddr, refPc);
					@(negedge clk);
					cycles++;
					if (cycles > memTimeout) failRun("timed out waiting for an APB transfer");
				end
				checkValue("paddr", paddr, st.memAddr);
				checkValue("pwrite", pwrite, st.memWr);
				if (st.memWr) begin
					checkValue("pwdata", pwdata, st.memData);
					refMem[st.memAddr[7:2]] = st.memData;
				end else begin
					st.regVal = refMem[st.memAddr[7:2]];
				end
			end else begin
				checkValue("psel", psel, 1'b0);  // No bus traffic
			end
			if (st.regWe && st.regAddr != 5'd0) refRegs[st.regAddr] = st.regVal;
			running = (st.nextPc != refPc);  // Self-jump ends the run
			refPc   = st.nextPc;
			retired++;
			if (retired > runLimit) failRun("program did not reach its final jump in time");
			@(negedge clk);
		end
		checkValue("instrAddr", instrAddr, refPc);
		if (dut0.props0.failCount != 0) begin
			failRun("an APB protocol assertion failed");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

/* compile.f */
common/scpuPkg.sv
hw/scpuCtrl.sv
hw/regFile.sv
hw/scpuAlu.sv
hw/apbDataPort.sv
hw/scpuCore.sv
test/scpuCore_properties.sv
test/scpuTb.sv
